/* source/ahb_pkg.sv */
//----------------------------------------------------------------------
// AHB-Lite bus constants shared by the cache and its downstream port
// Single 32-bit data bus, little-endian byte lanes
// Only IDLE and NONSEQ transfers are ever generated or accepted
//----------------------------------------------------------------------
`default_nettype none

package ahb_pkg;

	localparam int W_ADDR       = 32;
	localparam int W_DATA       = 32;
	localparam int W_STRB       = W_DATA / 8;   // One enable per byte lane
	localparam int BUS_SIZE_LOG = 2;            // log2 of bytes per bus word

	localparam logic [1:0] HTRANS_IDLE = 2'b00;
	localparam logic [1:0] HTRANS_NSEQ = 2'b10;
	localparam logic [2:0] HSIZE_WORD  = 3'b010;

	typedef logic [W_ADDR-1:0] addr_t;
	typedef logic [W_DATA-1:0] data_t;
	typedef logic [W_STRB-1:0] strb_t;

	// Byte lanes touched by a transfer of the given size at the given offset
	function automatic strb_t size_mask(input logic [2:0] size,
		input logic [BUS_SIZE_LOG-1:0] lo);
		strb_t base;
		base = (size >= HSIZE_WORD) ? '1 : strb_t'((1 << (1 << size)) - 1);
		return base << lo;
	endfunction

endpackage

`default_nettype wire

/* source/cache_pkg.sv */
//----------------------------------------------------------------------
// Geometry and FSM encoding of the direct-mapped write-back cache
// One bus word per line, so the index starts right above the byte
// offset and there is no word-in-line field
// Field positions assume a 32-bit address
//----------------------------------------------------------------------
`default_nettype none

package cache_pkg;

	localparam int DEPTH     = 64;      // Lines in the cache
	localparam int W_INDEX   = 6;       // log2(DEPTH)
	localparam int INDEX_LSB = 2;       // Index sits above the byte offset
	localparam int TAG_LSB   = INDEX_LSB + W_INDEX;
	localparam int W_TAG     = 32 - TAG_LSB;

	typedef logic [W_TAG-1:0]   tag_t;
	typedef logic [W_INDEX-1:0] index_t;

	// ------------------------------------------------------------------
	// Controller states
	typedef enum logic [3:0] {
		IDLE,             // No upstream data phase in progress
		READ_CHECK,       // Lookup result and read data are valid
		READ_CLEAN,       // Victim write data phase, fill address phase
		READ_FILL,        // Fill read data phase
		READ_DONE,        // Buffered fill word goes upstream
		WRITE_CHECK,      // Lookup result is valid, hit writes commit here
		WRITE_CLEAN,
		WRITE_FILL,
		WRITE_MODIFY,     // Merge upstream bytes into the fresh line
		WRITE_DONE,       // Okay response, next address phase sampled
		WRITE2READ_STALL  // Repeat the read lookup the write port blocked
	} cache_state_t;

endpackage

`default_nettype wire

/* source/cache_mem_if.sv */
//----------------------------------------------------------------------
// Tag and data port between the cache controller and the store
// Lookups are synchronous: hit, dirty, dirty_addr and rdata are valid
// the cycle after t_ren / d_ren. Writes land on the clock edge
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface cache_mem_if
	import ahb_pkg::*;
();

	// Tag side
	addr_t t_addr;
	logic  t_ren;
	logic  t_wen;
	logic  t_wvalid;
	logic  t_wdirty;
	logic  hit;
	logic  dirty;
	addr_t dirty_addr;    // Line address of the resident tag

	// Data side
	addr_t d_addr;
	logic  d_ren;
	strb_t d_wen;         // Per byte lane
	data_t wdata;
	data_t rdata;

	modport ctrl (
		output t_addr, t_ren, t_wen, t_wvalid, t_wdirty,
		output d_addr, d_ren, d_wen, wdata,
		input  hit, dirty, dirty_addr, rdata
	);

	modport store (
		input  t_addr, t_ren, t_wen, t_wvalid, t_wdirty,
		input  d_addr, d_ren, d_wen, wdata,
		output hit, dirty, dirty_addr, rdata
	);

endinterface

`default_nettype wire

/* source/cache_store.sv */
//----------------------------------------------------------------------
// Tag, valid, dirty and data arrays of the direct-mapped cache
// Hit and dirty come from the registered lookup, so they follow any
// tag write made after the lookup
// Valid and dirty clear on reset, tags and data are left undefined
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module cache_store
	import ahb_pkg::*;
	import cache_pkg::*;
(
	input  logic           clk,
	input  logic           rst_n,
	cache_mem_if.store     mem
);

	tag_t             tag_mem  [DEPTH];
	data_t            data_mem [DEPTH];
	logic [DEPTH-1:0] valid_bits;
	logic [DEPTH-1:0] dirty_bits;

	index_t           t_idx;
	tag_t             t_tag;
	index_t           d_idx;
	index_t           look_idx;     // Registered lookup
	tag_t             look_tag;
	data_t            rdata_q;

	assign t_idx = mem.t_addr[INDEX_LSB +: W_INDEX];
	assign t_tag = mem.t_addr[TAG_LSB +: W_TAG];
	assign d_idx = mem.d_addr[INDEX_LSB +: W_INDEX];

	// ------------------------------------------------------------------
	// Tag side
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_bits <= '0;   // Cache starts empty
			dirty_bits <= '0;
		end else if (mem.t_wen) begin
			valid_bits[t_idx] <= mem.t_wvalid;
			dirty_bits[t_idx] <= mem.t_wdirty;
		end
	end

	always_ff @(posedge clk) begin
		if (mem.t_wen)
			tag_mem[t_idx] <= t_tag;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			look_idx <= '0;
			look_tag <= '0;
		end else if (mem.t_ren) begin
			look_idx <= t_idx;
			look_tag <= t_tag;
		end
	end

	assign mem.hit   = valid_bits[look_idx] && (tag_mem[look_idx] == look_tag);
	assign mem.dirty = valid_bits[look_idx] && dirty_bits[look_idx];  // Invalid is never dirty

	// Victim address rebuilt from the stored tag
	assign mem.dirty_addr = {tag_mem[look_idx], look_idx, {INDEX_LSB{1'b0}}};

	// ------------------------------------------------------------------
	// Data side, byte-lane writes and a registered read
	always_ff @(posedge clk) begin
		for (int i = 0; i < W_STRB; i++) begin
			if (mem.d_wen[i])
				data_mem[d_idx][i*8 +: 8] <= mem.wdata[i*8 +: 8];
		end
		if (mem.d_ren)
			rdata_q <= data_mem[d_idx];   // Old contents on a same-cycle write
	end

	assign mem.rdata = rdata_q;

endmodule

`default_nettype wire

/* source/cache_ctrl.sv */
//----------------------------------------------------------------------
// Write-back cache controller FSM and cache-memory steering
// Assumes src_hready is the bus HREADY, i.e. our own src_hready_resp
// in a single-slave system
// Downstream must hold dst_hready high when it has no data phase
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl
	import ahb_pkg::*;
	import cache_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          src_hready,
	input  logic [1:0]    src_htrans,
	input  logic          src_hwrite,
	input  logic [2:0]    src_hsize,
	input  addr_t         src_haddr,
	input  data_t         src_hwdata,
	input  logic          dst_hready,
	input  data_t         dst_hrdata,
	input  logic          dst_dphase_active,
	input  data_t         fill_word,        // Buffered fill data from the downstream port
	cache_mem_if.ctrl     mem,
	output cache_state_t  state,
	output logic          hit,
	output logic          dirty,
	output addr_t         src_addr_dphase,
	output logic          src_hready_resp,
	output data_t         src_hrdata
);

	logic [2:0]   src_size_dphase;
	logic         src_aphase_read;
	logic         src_aphase_write;
	logic         src_aphase;
	cache_state_t next_or_idle;
	cache_state_t state_next;
	logic         in_check;
	logic         in_clean_aphase;
	logic         maybe_modify;
	logic         wen_modify;
	logic         wen_fill;

	assign hit   = mem.hit;
	assign dirty = mem.dirty;

	assign src_aphase_read  = src_hready && src_htrans == HTRANS_NSEQ && !src_hwrite;
	assign src_aphase_write = src_hready && src_htrans == HTRANS_NSEQ && src_hwrite;
	assign src_aphase       = src_aphase_read || src_aphase_write;

	assign next_or_idle = src_aphase_read  ? READ_CHECK  :
	                      src_aphase_write ? WRITE_CHECK : IDLE;

	// Address and size of the transfer now in its data phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			src_addr_dphase <= '0;
			src_size_dphase <= '0;
		end else if (src_aphase) begin
			src_addr_dphase <= src_haddr;
			src_size_dphase <= src_hsize;
		end
	end

	// ------------------------------------------------------------------
	// State machine
	always_comb begin
		state_next = state;
		case (state)
		IDLE, READ_DONE, WRITE_DONE: state_next = next_or_idle;
		READ_CHECK: begin
			if (hit)
				state_next = next_or_idle;
			else if (dst_hready)                      // Clean or fill address phase goes out
				state_next = dirty ? READ_CLEAN : READ_FILL;
		end
		READ_CLEAN:  if (dst_hready) state_next = READ_FILL;
		READ_FILL:   if (dst_hready) state_next = READ_DONE;
		WRITE_CHECK: begin
			if (hit && !dirty)
				state_next = WRITE_DONE;              // Tag needs its dirty bit set
			else if (hit && src_aphase_read)
				state_next = WRITE2READ_STALL;        // Data port busy with this write
			else if (hit)
				state_next = next_or_idle;
			else if (dst_hready)
				state_next = dirty ? WRITE_CLEAN : WRITE_FILL;
		end
		WRITE_CLEAN:      if (dst_hready) state_next = WRITE_FILL;
		WRITE_FILL:       if (dst_hready) state_next = WRITE_MODIFY;
		WRITE_MODIFY:     state_next = WRITE_DONE;
		WRITE2READ_STALL: state_next = READ_CHECK;
		default:          state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_next;
	end

	// ------------------------------------------------------------------
	// Cache memory steering
	assign in_check        = state == READ_CHECK || state == WRITE_CHECK;
	assign in_clean_aphase = in_check && !hit && dirty;
	assign maybe_modify    = state == WRITE_CHECK || state == WRITE_MODIFY;
	assign wen_modify      = (state == WRITE_CHECK && hit) || state == WRITE_MODIFY;
	assign wen_fill        = dst_hready && dst_dphase_active &&
	                         (state == READ_FILL || state == WRITE_FILL);

	// Writes always target the data-phase address, lookups the new one
	assign mem.t_addr   = src_aphase ? src_haddr : src_addr_dphase;
	assign mem.t_ren    = src_aphase || state == WRITE2READ_STALL;
	assign mem.t_wen    = (wen_modify && !(hit && dirty)) || wen_fill;
	assign mem.t_wvalid = wen_modify || wen_fill;
	assign mem.t_wdirty = wen_modify;

	assign mem.d_addr = in_clean_aphase                           ? mem.dirty_addr :
	                    (src_aphase && state != WRITE_CHECK)      ? src_haddr      :
	                                                                src_addr_dphase;
	assign mem.d_ren  = (src_aphase_read && state != WRITE_CHECK) ||
	                    state == WRITE2READ_STALL ||
	                    (in_clean_aphase && dst_hready);          // Victim word for dst_hwdata
	assign mem.d_wen  = {W_STRB{wen_fill}} |
	                    (size_mask(src_size_dphase, src_addr_dphase[BUS_SIZE_LOG-1:0]) &
	                     {W_STRB{wen_modify}});
	assign mem.wdata  = maybe_modify ? src_hwdata : dst_hrdata;

	// ------------------------------------------------------------------
	// Upstream response
	assign src_hready_resp = state == IDLE ||
	                         (state == READ_CHECK && hit) ||
	                         state == READ_DONE ||
	                         (state == WRITE_CHECK && hit && dirty) ||
	                         state == WRITE_DONE;

	assign src_hrdata = (state == READ_DONE) ? fill_word : mem.rdata;

endmodule

`default_nettype wire

/* source/ahb_dst_port.sv */
//----------------------------------------------------------------------
// Downstream AHB-Lite master side of the cache
// Single-word NONSEQ transfers only, HSIZE is always a word
// The clean address phase overlaps the CHECK state, the fill address
// phase overlaps the clean data phase
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ahb_dst_port
	import ahb_pkg::*;
	import cache_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  cache_state_t  state,
	input  logic          hit,
	input  logic          dirty,
	input  addr_t         src_addr_dphase,
	input  addr_t         dirty_addr,
	input  data_t         cache_rdata,
	input  logic          dst_hready,
	input  data_t         dst_hrdata,
	output addr_t         dst_haddr,
	output logic [1:0]    dst_htrans,
	output logic          dst_hwrite,
	output data_t         dst_hwdata,
	output logic          dst_dphase_active,
	output data_t         fill_word
);

	logic  check_miss;
	logic  in_clean_aphase;
	logic  in_fill;
	addr_t fill_addr;

	assign check_miss      = (state == READ_CHECK || state == WRITE_CHECK) && !hit;
	assign in_clean_aphase = check_miss && dirty;
	assign in_fill         = state == READ_FILL || state == WRITE_FILL;

	// Line is one word, so the fill is the word-aligned request address
	assign fill_addr = {src_addr_dphase[W_ADDR-1:BUS_SIZE_LOG], {BUS_SIZE_LOG{1'b0}}};

	// ------------------------------------------------------------------
	// Address phase
	assign dst_htrans = (check_miss || state == READ_CLEAN || state == WRITE_CLEAN) ?
	                    HTRANS_NSEQ : HTRANS_IDLE;
	assign dst_hwrite = in_clean_aphase;
	assign dst_haddr  = in_clean_aphase ? dirty_addr : fill_addr;

	// Victim word was read from the store during the clean address phase
	assign dst_hwdata = cache_rdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dst_dphase_active <= 1'b0;
		else if (dst_hready)
			dst_dphase_active <= dst_htrans == HTRANS_NSEQ;
	end

	// ------------------------------------------------------------------
	// Fill data buffer, cuts the dst_hrdata to src_hrdata path
	always_ff @(posedge clk) begin
		if (dst_hready && dst_dphase_active && in_fill)
			fill_word <= dst_hrdata;
	end

endmodule

`default_nettype wire

/* source/ahb_wb_cache.sv */
//----------------------------------------------------------------------
// AHB-Lite write-back cache, 64 lines of one word, direct mapped
// Upstream: AHB-Lite slave, no error response, all transfers cached
// Downstream: AHB-Lite master, word-sized NONSEQ transfers, no errors
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ahb_wb_cache
	import ahb_pkg::*;
	import cache_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	// Upstream slave
	input  logic          src_hready,
	input  logic [1:0]    src_htrans,
	input  logic          src_hwrite,
	input  addr_t         src_haddr,
	input  logic [2:0]    src_hsize,
	input  data_t         src_hwdata,
	output logic          src_hready_resp,
	output data_t         src_hrdata,
	// Downstream master
	output addr_t         dst_haddr,
	output logic [1:0]    dst_htrans,
	output logic          dst_hwrite,
	output data_t         dst_hwdata,
	input  logic          dst_hready,
	input  data_t         dst_hrdata
);

	cache_state_t state;
	logic         hit;
	logic         dirty;
	addr_t        src_addr_dphase;
	logic         dst_dphase_active;
	data_t        fill_word;

	cache_mem_if mem_if ();

	cache_store store_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.mem   (mem_if.store)
	);

	cache_ctrl ctrl_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.src_hready        (src_hready),
		.src_htrans        (src_htrans),
		.src_hwrite        (src_hwrite),
		.src_hsize         (src_hsize),
		.src_haddr         (src_haddr),
		.src_hwdata        (src_hwdata),
		.dst_hready        (dst_hready),
		.dst_hrdata        (dst_hrdata),
		.dst_dphase_active (dst_dphase_active),
		.fill_word         (fill_word),
		.mem               (mem_if.ctrl),
		.state             (state),
		.hit               (hit),
		.dirty             (dirty),
		.src_addr_dphase   (src_addr_dphase),
		.src_hready_resp   (src_hready_resp),
		.src_hrdata        (src_hrdata)
	);

	ahb_dst_port dst_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.state             (state),
		.hit               (hit),
		.dirty             (dirty),
		.src_addr_dphase   (src_addr_dphase),
		.dirty_addr        (mem_if.dirty_addr),
		.cache_rdata       (mem_if.rdata),
		.dst_hready        (dst_hready),
		.dst_hrdata        (dst_hrdata),
		.dst_haddr         (dst_haddr),
		.dst_htrans        (dst_htrans),
		.dst_hwrite        (dst_hwrite),
		.dst_hwdata        (dst_hwdata),
		.dst_dphase_active (dst_dphase_active),
		.fill_word         (fill_word)
	);

endmodule

`default_nettype wire

/* sim/ahb_wb_cache_chk.sv */
//----------------------------------------------------------------------
// Protocol and cache invariants, bound to the cache top level
// Reads the controller state from inside the top level
// Assumes src_hready is the cache's own src_hready_resp looped back
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ahb_wb_cache_chk
	import ahb_pkg::*;
	import cache_pkg::*;
(
	input wire logic         clk,
	input wire logic         rst_n,
	input wire logic         src_hready,
	input wire logic [1:0]   src_htrans,
	input wire addr_t        dst_haddr,
	input wire logic [1:0]   dst_htrans,
	input wire logic         dst_hready,
	input wire logic         src_hready_resp,
	input wire cache_state_t state
);

	// Address phase held while downstream stalls
	a_dst_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(dst_htrans == HTRANS_NSEQ && !dst_hready) |=>
		($stable(dst_haddr) && $stable(dst_htrans)))
		else $error("downstream address phase changed during a wait state");

	a_idle_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> dst_htrans == HTRANS_IDLE)
		else $error("downstream htrans not IDLE after reset");

	// Data phase ends with no new transfer, so the cache drops to IDLE and stays ready
	a_idle_ready: assert property (@(posedge clk) disable iff (!rst_n)
		(src_hready && src_htrans != HTRANS_NSEQ) |=>
		(state == IDLE && src_hready_resp))
		else $error("cache not idle and ready after a data phase with no new transfer");

endmodule

bind ahb_wb_cache ahb_wb_cache_chk chk_inst (
	.clk             (clk),
	.rst_n           (rst_n),
	.src_hready      (src_hready),
	.src_htrans      (src_htrans),
	.dst_haddr       (dst_haddr),
	.dst_htrans      (dst_htrans),
	.dst_hready      (dst_hready),
	.src_hready_resp (src_hready_resp),
	.state           (state)
);

`default_nettype wire

/* sim/tb_ahb_wb_cache.sv */
//----------------------------------------------------------------------
// Testbench for the AHB-Lite write-back cache
// Upstream master is non-pipelined, src_hready is looped back from
// src_hready_resp as in a single-slave system
// Downstream memory covers the 1 KiB test window only
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_ahb_wb_cache
	import ahb_pkg::*;
	import cache_pkg::*;
();

	localparam int SEED        = 42;
	localparam int N_RAND      = 2000;   // Random transfers
	localparam int N_WORDS     = 256;    // Words in the 1 KiB window
	localparam int WAIT_PCT    = 30;     // Downstream wait-state probability
	localparam int WATCHDOG_NS = (N_RAND + N_WORDS) * 40 * 8;

	logic clk = 1'b0;
	logic rst_n;
	logic [1:0] src_htrans;
	logic src_hwrite;
	addr_t src_haddr;
	logic [2:0] src_hsize;
	data_t src_hwdata;
	logic src_hready_resp;
	data_t src_hrdata;
	addr_t dst_haddr;
	logic [1:0] dst_htrans;
	logic dst_hwrite;
	data_t dst_hwdata;
	logic dst_hready;
	data_t dst_hrdata;

	data_t dmem [N_WORDS];       // Downstream memory
	data_t ref_mem [N_WORDS];    // Reference contents as seen upstream
	logic m_valid [DEPTH];       // Direct-mapped model
	logic m_dirty [DEPTH];
	tag_t m_tag [DEPTH];

	// Downstream slave state
	logic dp_act;
	logic dp_wr;
	addr_t dp_addr;
	int dwait;
	logic nx_ready = 1'b1;       // Idle slave is ready
	data_t nx_rdata = '0;

	// Downstream activity seen during one upstream transfer
	int dn_wr_cnt;
	int dn_rd_cnt;
	addr_t dn_wr_addr;
	addr_t dn_rd_addr;
	data_t dn_wr_data;
	logic dn_order_bad;

	int errors = 0;

	always #4 clk = ~clk;   // 8 ns period

	ahb_wb_cache ahb_wb_cache_inst (
		.clk(clk), .rst_n(rst_n),
		.src_hready(src_hready_resp), .src_htrans(src_htrans), .src_hwrite(src_hwrite),
		.src_haddr(src_haddr), .src_hsize(src_hsize), .src_hwdata(src_hwdata),
		.src_hready_resp(src_hready_resp), .src_hrdata(src_hrdata),
		.dst_haddr(dst_haddr), .dst_htrans(dst_htrans), .dst_hwrite(dst_hwrite),
		.dst_hwdata(dst_hwdata), .dst_hready(dst_hready), .dst_hrdata(dst_hrdata)
	);

	// ------------------------------------------------------------------
	// Downstream memory decides at negedge and drives after the posedge
	always @(negedge clk) begin
		if (!rst_n) begin
			dp_act   = 1'b0;
			dwait    = 0;
			nx_ready = 1'b1;
		end else begin
			if (dst_hready) begin
				if (dp_act && dp_wr) begin   // Write data phase completes
					dmem[dp_addr[9:2]] = dst_hwdata;
					dn_wr_data = dst_hwdata;
				end
				dp_act = (dst_htrans == HTRANS_NSEQ);
				if (dp_act) begin
					dp_wr   = dst_hwrite;
					dp_addr = dst_haddr;
					if (dst_hwrite) begin
						dn_wr_cnt++;
						dn_wr_addr = dst_haddr;
						if (dn_rd_cnt != 0)
							dn_order_bad = 1'b1;   // Clean must precede fill
					end else begin
						dn_rd_cnt++;
						dn_rd_addr = dst_haddr;
					end
					dwait = ($urandom % 100 < WAIT_PCT) ? int'(1 + $urandom % 3) : 0;
				end
			end else if (dwait > 0) begin
				dwait--;
			end
			nx_ready = !dp_act || dwait == 0;
			nx_rdata = (dp_act && !dp_wr) ? dmem[dp_addr[9:2]] : 32'h0;
		end
	end

	always @(posedge clk) begin
		#1;
		dst_hready = nx_ready;
		dst_hrdata = nx_rdata;
	end

	// Byte lanes of an upstream transfer
	function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [1:0] off);
		case (size)
		3'd0:    lane_mask = 4'b0001 << off;
		3'd1:    lane_mask = 4'b0011 << off;
		default: lane_mask = 4'b1111;
		endcase
	endfunction

	task automatic report(input string name, input data_t exp, input data_t act);
		errors++;
		$display("** Error %s: expected %h, actual %h at %0t", name, exp, act, $time);
	endtask

	// ------------------------------------------------------------------
	// One upstream transfer checked against the model
	task automatic run_check(input logic wr, input addr_t addr, input logic [2:0] size,
		input data_t wdata);
		logic [3:0] mask;
		index_t idx;
		tag_t tg;
		logic exp_hit;
		logic exp_clean;
		addr_t victim;
		data_t victim_data;
		data_t rdata;
		int waits;
		mask        = lane_mask(size, addr[1:0]);
		idx         = addr[INDEX_LSB +: W_INDEX];
		tg          = addr[TAG_LSB +: W_TAG];
		exp_hit     = m_valid[idx] && m_tag[idx] == tg;
		exp_clean   = !exp_hit && m_valid[idx] && m_dirty[idx];
		victim      = {m_tag[idx], idx, 2'b00};
		victim_data = ref_mem[victim[9:2]];
		dn_wr_cnt    = 0;
		dn_rd_cnt    = 0;
		dn_order_bad = 1'b0;
		// The idle cache accepts this address phase at the next edge
		src_htrans = HTRANS_NSEQ;
		src_haddr  = addr;
		src_hwrite = wr;
		src_hsize  = size;
		@(posedge clk);
		#1;
		src_htrans = HTRANS_IDLE;
		src_hwdata = wdata;
		waits = 0;
		@(negedge clk);
		while (!src_hready_resp) begin
			waits++;
			@(negedge clk);
		end
		rdata = src_hrdata;
		@(posedge clk);
		#1;
		for (int b = 0; b < 4; b++) begin
			if (mask[b] && wr)
				ref_mem[addr[9:2]][b*8 +: 8] = wdata[b*8 +: 8];
		end
		if (!wr) begin
			for (int b = 0; b < 4; b++) begin
				if (mask[b] && rdata[b*8 +: 8] !== ref_mem[addr[9:2]][b*8 +: 8])
					report("read_data", ref_mem[addr[9:2]], rdata);
			end
			if (exp_hit && waits != 0)
				report("read_hit_waits", 32'd0, data_t'(waits));
		end
		if (exp_hit) begin
			if (dn_wr_cnt != 0 || dn_rd_cnt != 0) begin
				errors++;
				$display("** Error hit_idle: downstream transfer on a hit to %h", addr);
			end
		end else begin
			if (dn_wr_cnt != (exp_clean ? 1 : 0))
				report("clean_count", data_t'(exp_clean), data_t'(dn_wr_cnt));
			if (exp_clean && dn_wr_addr !== victim)
				report("clean_addr", victim, dn_wr_addr);
			if (exp_clean && dn_wr_data !== victim_data)
				report("clean_data", victim_data, dn_wr_data);
			if (dn_rd_cnt != 1)
				report("fill_count", 32'd1, data_t'(dn_rd_cnt));
			if (dn_rd_addr !== {addr[31:2], 2'b00})
				report("fill_addr", {addr[31:2], 2'b00}, dn_rd_addr);
			if (dn_order_bad) begin
				errors++;
				$display("Fill read to %h was issued before the clean write", addr);
			end
		end
		m_dirty[idx] = exp_hit ? (m_dirty[idx] || wr) : wr;
		m_valid[idx] = 1'b1;
		m_tag[idx]   = tg;
	endtask

	// ------------------------------------------------------------------
	initial begin
		logic wr;
		logic [2:0] size;
		addr_t addr;
		void'($urandom(SEED));
		rst_n      = 1'b0;
		src_htrans = HTRANS_IDLE;
		src_hwrite = 1'b0;
		src_haddr  = '0;
		src_hsize  = HSIZE_WORD;
		src_hwdata = '0;
		dst_hready = 1'b1;
		dst_hrdata = '0;
		dn_wr_cnt  = 0;
		dn_rd_cnt  = 0;
		dn_order_bad = 1'b0;
		for (int i = 0; i < N_WORDS; i++) begin
			dmem[i]    = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3 + i[7:0]};
			ref_mem[i] = dmem[i];
		end
		for (int i = 0; i < DEPTH; i++) begin
			m_valid[i] = 1'b0;
			m_dirty[i] = 1'b0;
			m_tag[i]   = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		if (dst_htrans !== HTRANS_IDLE || dst_hwrite !== 1'b0) begin
			errors++;
			$display("Downstream bus is not idle after reset");
		end
		@(posedge clk);
		#1;
		for (int n = 0; n < N_RAND; n++) begin
			wr   = 1'($urandom % 2);
			size = 3'($urandom % 3);
			addr = addr_t'($urandom % 1024);
			if (size == 3'd1)
				addr[0] = 1'b0;
			if (size == 3'd2)
				addr[1:0] = 2'b00;
			run_check(wr, addr, size, data_t'($urandom));
		end
		// Reading back the whole window cleans every dirty line
		for (int i = 0; i < N_WORDS; i++)
			run_check(1'b0, addr_t'(i * 4), HSIZE_WORD, 32'h0);
		for (int i = 0; i < N_WORDS; i++) begin
			if (dmem[i] !== ref_mem[i])
				report("final_memory", ref_mem[i], dmem[i]);
		end
		$display("Checks done, errors: %0d", errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the cache did not finish its transfers in time");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
source/ahb_pkg.sv
source/cache_pkg.sv
source/cache_mem_if.sv
source/cache_store.sv
source/cache_ctrl.sv
source/ahb_dst_port.sv
source/ahb_wb_cache.sv
sim/ahb_wb_cache_chk.sv
sim/tb_ahb_wb_cache.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_ahb_wb_cache
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
